// ==== verilog.f ====
common/decode_pkg.sv
common/src_operand_if.sv
decode/instr_field_decoder.sv
decode/hazard_detector.sv
decode/register_file.sv
decode/decode_stage_regs.sv
rtl/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail, a missing pass line makes grep fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/decode_stage_tb.sv ====
// decode stage testbench with reference model, per-cycle output compare and timeout
`timescale 1ns/100ps

module decode_stage_tb
    import decode_pkg::*;
();

    // about three times the ~300 stimulus cycles
    localparam int max_cycles = 1000;
    localparam logic [13*7-1:0] op_list = {op_r, op_r_w, op_jalr, op_load, op_imm, op_imm_w,
        op_store, op_branch, op_lui, op_auipc, op_jal, op_fence, op_system};

    logic clk, reset, wr_en, alu_st_dec, decoder_flush, icache_fetch_miss, alustall;
    logic [instr_w-1:0] instr, out_instr;
    logic [xlen-1:0] prog_counter, destn_data, rd_data_a, rd_data_b, curr_pc;
    logic [reg_addr_w-1:0] destn_reg, alu_reg_dest, mem_reg_dest, wb_reg_dest, reg_dest, reg_a;
    logic [uimm_w-1:0] uimm;
    logic [func_w-1:0] opcode;
    logic [imm12_w-1:0] reg_b;

    // reference state
    logic [xlen-1:0] model_regs [num_regs];
    logic [xlen-1:0] exp_a = '0, exp_b = '0, exp_pc = '0;
    logic [reg_addr_w-1:0] exp_dest = '0, exp_ra = '0;
    logic [uimm_w-1:0] exp_u = '0;
    logic [func_w-1:0] exp_opc = '0;
    logic [instr_w-1:0] exp_instr = '0, word;
    logic [imm12_w-1:0] exp_rb = '0;
    logic exp_stall = 1'b0, flush_q = 1'b0, check_en = 1'b0;
    logic [reg_addr_w-1:0] r1, r2, rd_sel, prev;
    integer seed = 32'h6786_30a6;
    int errors = 0, checks = 0, stall_seen = 0, cycles = 0;

    decode_stage dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic conflicts(input logic [4:0] rs, input logic [4:0] d_alu,
                                       input logic [4:0] d_mem, input logic [4:0] d_wb,
                                       input logic st);
        return rs != 5'd0 && ((rs == d_alu && !st) || rs == d_mem || rs == d_wb);
    endfunction

    // source use per major opcode
    function automatic logic uses_rs1(input logic [6:0] op);
        return op inside {op_r, op_r_w, op_load, op_imm, op_imm_w, op_store, op_branch,
                          op_jalr, op_system};
    endfunction

    function automatic logic uses_rs2(input logic [6:0] op);
        return op inside {op_r, op_r_w, op_store, op_branch};
    endfunction

    // raw hazard of one word against the three in-flight destinations
    function automatic logic source_hazard(input logic [31:0] w, input logic [4:0] d_alu,
                                           input logic [4:0] d_mem, input logic [4:0] d_wb,
                                           input logic st);
        return (uses_rs1(w[6:0]) && conflicts(w[19:15], d_alu, d_mem, d_wb, st)) ||
               (uses_rs2(w[6:0]) && conflicts(w[24:20], d_alu, d_mem, d_wb, st));
    endfunction

    // expected outputs after the edge, from the inputs held before it
    function automatic void predict(input logic [31:0] w, input logic [63:0] pc,
        input logic [4:0] d_alu, input logic [4:0] d_mem, input logic [4:0] d_wb,
        input logic st, input logic fl, input logic miss, input logic stall_q,
        input logic fl_q, input logic [63:0] a_q, input logic [63:0] b_q,
        input logic [19:0] u_q, output logic [63:0] a, output logic [63:0] b,
        output logic [4:0] dest, output logic [19:0] u, output logic [9:0] opc,
        output logic [31:0] w_o, output logic [63:0] pc_o, output logic [4:0] ra,
        output logic [11:0] rb, output logic stall);
        logic [6:0] op;
        logic use1, use2, hz, hold;
        logic [19:0] u_new;
        op = w[6:0];
        use1 = uses_rs1(op);
        use2 = uses_rs2(op);
        hz = source_hazard(w, d_alu, d_mem, d_wb, st);
        hold = hz || stall_q;
        // u immediate as is, j immediate back in order 20..1
        if (op == op_lui || op == op_auipc) begin
            u_new = w[31:12];
        end else if (op == op_jal) begin
            u_new = {w[31], w[19:12], w[20], w[30:21]};
        end else begin
            u_new = '0;
        end
        a = hold ? a_q : (use1 ? model_regs[w[19:15]] : 64'd0);
        b = hold ? b_q : (use2 ? model_regs[w[24:20]] : 64'd0);
        u = hold ? u_q : u_new;
        dest = (hold || fl || fl_q || miss || op == op_fence) ? 5'd0 : w[11:7];
        opc = fl_q ? func_bubble : {w[14:12], op};
        w_o = w;
        pc_o = pc;
        ra = w[19:15];
        rb = w[31:20];
        stall = hz;
    endfunction

    function automatic logic [31:0] r_instr(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [4:0] rd);
        return {7'd0, rs2, rs1, 3'b000, rd, op_r};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        int idx;
        w = $random(seed);
        idx = {$random(seed)} % 13;
        w[6:0] = op_list[idx*7 +: 7];
        return w;
    endfunction

    function automatic logic [4:0] rand_reg_nz();
        return 5'(({$random(seed)} % 31) + 1);
    endfunction

    task automatic apply(input logic [31:0] w, input logic we, input logic [4:0] wreg,
        input logic [63:0] wdata, input logic [4:0] d_alu, input logic [4:0] d_mem,
        input logic [4:0] d_wb, input logic st, input logic fl, input logic miss);
        @(posedge clk);
        instr <= w;
        prog_counter <= {$random(seed), $random(seed)};
        wr_en <= we;
        destn_reg <= wreg;
        destn_data <= wdata;
        alu_reg_dest <= d_alu;
        mem_reg_dest <= d_mem;
        wb_reg_dest <= d_wb;
        alu_st_dec <= st;
        decoder_flush <= fl;
        icache_fetch_miss <= miss;
    endtask

    task automatic issue(input logic [31:0] w);
        apply(w, 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // hazard cycle, then the word held while the stall drains
    task automatic stall_with(input logic [31:0] w, input logic [4:0] d_alu,
                              input logic [4:0] d_mem, input logic [4:0] d_wb, input logic st);
        apply(w, 1'b0, '0, '0, d_alu, d_mem, d_wb, st, 1'b0, 1'b0);
        issue(w);
        issue(w);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        errors++;
        $display("Fail at %0t: %s expected %0h, actual %0h", $time, name, exp_v, act_v);
    endtask

    // model steps on the same edge as the dut, writes land after the reads
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                model_regs[i] = '0;
            end
            {exp_a, exp_b, exp_dest, exp_u, exp_opc, exp_stall, flush_q, check_en} = '0;
        end else begin
            predict(instr, prog_counter, alu_reg_dest, mem_reg_dest, wb_reg_dest, alu_st_dec,
                decoder_flush, icache_fetch_miss, exp_stall, flush_q, exp_a, exp_b, exp_u,
                exp_a, exp_b, exp_dest, exp_u, exp_opc, exp_instr, exp_pc, exp_ra, exp_rb,
                exp_stall);
            if (wr_en && destn_reg != 5'd0) begin
                model_regs[destn_reg] = destn_data;
            end
            flush_q = decoder_flush;
            check_en = 1'b1;
        end
    end

    // outputs settled half a period after the edge
    always @(negedge clk) begin
        if (check_en) begin
            checks++;
            if (rd_data_a !== exp_a) report_mismatch("rd_data_a", exp_a, rd_data_a);
            if (rd_data_b !== exp_b) report_mismatch("rd_data_b", exp_b, rd_data_b);
            if (reg_dest !== exp_dest) report_mismatch("reg_dest", 64'(exp_dest), 64'(reg_dest));
            if (uimm !== exp_u) report_mismatch("uimm", 64'(exp_u), 64'(uimm));
            if (opcode !== exp_opc) report_mismatch("opcode", 64'(exp_opc), 64'(opcode));
            if (out_instr !== exp_instr) begin
                report_mismatch("out_instr", 64'(exp_instr), 64'(out_instr));
            end
            if (curr_pc !== exp_pc) report_mismatch("curr_pc", exp_pc, curr_pc);
            if (reg_a !== exp_ra) report_mismatch("reg_a", 64'(exp_ra), 64'(reg_a));
            if (reg_b !== exp_rb) report_mismatch("reg_b", 64'(exp_rb), 64'(reg_b));
            if (alustall !== exp_stall) report_mismatch("alustall", 64'(exp_stall), 64'(alustall));
            if (alustall) stall_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == max_cycles) begin
            $display("timeout, run did not finish within %0d cycles", max_cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        {clk, wr_en, alu_st_dec, decoder_flush, icache_fetch_miss} = '0;
        {instr, prog_counter, destn_reg, destn_data} = '0;
        {alu_reg_dest, mem_reg_dest, wb_reg_dest} = '0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // writes, read in the write cycle sees the old value
        prev = rand_reg_nz();
        for (int k = 0; k < 16; k++) begin
            r1 = rand_reg_nz();
            word = r_instr(r1, prev, rand_reg_nz());
            apply(word, 1'b1, r1, {$random(seed), $random(seed)}, '0, '0, '0, 1'b0, 1'b0, 1'b0);
            issue(word);
            prev = r1;
        end
        // x0 write dropped
        apply(r_instr(5'd0, prev, 5'd1), 1'b1, '0, {$random(seed), $random(seed)},
              '0, '0, '0, 1'b0, 1'b0, 1'b0);
        issue(r_instr(5'd0, 5'd0, 5'd1));

        // every major opcode with random fields
        for (int i = 0; i < 13; i++) begin
            for (int j = 0; j < 6; j++) begin
                word = $random(seed);
                word[6:0] = op_list[i*7 +: 7];
                issue(word);
            end
        end

        // alu, alu masked, mem, wb, then immediate bits that look like rs2
        for (int k = 0; k < 4; k++) begin
            r1 = rand_reg_nz();
            r2 = rand_reg_nz();
            rd_sel = rand_reg_nz();
            word = r_instr(r1, r2, rd_sel);
            stall_with(word, r1, '0, '0, 1'b0);
            stall_with(word, r1, '0, '0, 1'b1);
            stall_with(word, '0, r2, '0, 1'b0);
            stall_with(word, '0, '0, r1, 1'b0);
            stall_with({7'd0, r2, 5'd0, 3'b000, rd_sel, op_imm}, r2, r2, r2, 1'b0);
        end
        if (stall_seen == 0) begin
            errors++;
            $display("hazard section finished without alustall ever going high");
        end

        // flush bubble, then fetch miss alone
        for (int k = 0; k < 2; k++) begin
            apply(random_instr(), 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b1, 1'b0);
            issue(random_instr());
            issue(random_instr());
            apply(random_instr(), 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b1);
            issue(random_instr());
        end

        // mixed traffic on small register numbers so hazards occur
        for (int k = 0; k < 120; k++) begin
            @(negedge clk);
            // hazard now raises alustall next cycle and the word must stay
            if (source_hazard(instr, alu_reg_dest, mem_reg_dest, wb_reg_dest,
                              alu_st_dec)) begin
                word = instr;
            end else begin
                word = random_instr();
                word[19:15] = 5'({$random(seed)} % 4);
                word[24:20] = 5'({$random(seed)} % 4);
            end
            apply(word, 1'($random(seed)), 5'($random(seed)), {$random(seed), $random(seed)},
                  5'({$random(seed)} % 4), 5'({$random(seed)} % 4), 5'({$random(seed)} % 4),
                  1'($random(seed)), ({$random(seed)} % 16 == 0), ({$random(seed)} % 16 == 0));
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rtl/decode_stage.sv ====
// rv64i decode stage top, field decode, register file, hazard check and alu pipeline register
`timescale 1ns/100ps

module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [instr_w-1:0]    instr,
    input  logic [xlen-1:0]       prog_counter,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] destn_reg,
    input  logic [xlen-1:0]       destn_data,
    input  logic [reg_addr_w-1:0] alu_reg_dest,
    input  logic [reg_addr_w-1:0] mem_reg_dest,
    input  logic [reg_addr_w-1:0] wb_reg_dest,
    input  logic                  alu_st_dec,
    input  logic                  decoder_flush,
    input  logic                  icache_fetch_miss,
    output logic [xlen-1:0]       rd_data_a,
    output logic [xlen-1:0]       rd_data_b,
    output logic [reg_addr_w-1:0] reg_dest,
    output logic [uimm_w-1:0]     uimm,
    output logic [func_w-1:0]     opcode,
    output logic [instr_w-1:0]    out_instr,
    output logic [xlen-1:0]       curr_pc,
    output logic [reg_addr_w-1:0] reg_a,
    output logic [imm12_w-1:0]    reg_b,
    output logic                  alustall
);

    // decoded fields before the pipeline register
    logic [reg_addr_w-1:0] rd;
    logic [func_w-1:0]     func_code;
    logic [uimm_w-1:0]     uimm_next;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  hazard;

    src_operand_if src_i ();

    instr_field_decoder field_dec_i (
        .instr     (instr),
        .src       (src_i.decoder),
        .rd        (rd),
        .func_code (func_code),
        .uimm_next (uimm_next)
    );

    hazard_detector hazard_i (
        .clk          (clk),
        .reset        (reset),
        .src          (src_i.consumer),
        .alu_reg_dest (alu_reg_dest),
        .mem_reg_dest (mem_reg_dest),
        .wb_reg_dest  (wb_reg_dest),
        .alu_st_dec   (alu_st_dec),
        .hazard       (hazard),
        .alustall     (alustall)
    );

    // writeback port comes straight from the top
    register_file regfile_i (
        .clk        (clk),
        .reset      (reset),
        .src        (src_i.consumer),
        .wr_en      (wr_en),
        .destn_reg  (destn_reg),
        .destn_data (destn_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    decode_stage_regs stage_regs_i (
        .clk               (clk),
        .reset             (reset),
        .instr             (instr),
        .prog_counter      (prog_counter),
        .rd                (rd),
        .func_code         (func_code),
        .uimm_next         (uimm_next),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .hazard            (hazard),
        .alustall          (alustall),
        .decoder_flush     (decoder_flush),
        .icache_fetch_miss (icache_fetch_miss),
        .rd_data_a         (rd_data_a),
        .rd_data_b         (rd_data_b),
        .reg_dest          (reg_dest),
        .uimm              (uimm),
        .opcode            (opcode),
        .out_instr         (out_instr),
        .curr_pc           (curr_pc),
        .reg_a             (reg_a),
        .reg_b             (reg_b)
    );

endmodule

// ==== decode/decode_stage_regs.sv ====
// decode to alu pipeline register with stall hold, flush bubble and fetch-miss kill
`timescale 1ns/100ps

module decode_stage_regs
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [instr_w-1:0]    instr,
    input  logic [xlen-1:0]       prog_counter,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [func_w-1:0]     func_code,
    input  logic [uimm_w-1:0]     uimm_next,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data,
    input  logic                  hazard,
    input  logic                  alustall,
    input  logic                  decoder_flush,
    input  logic                  icache_fetch_miss,
    output logic [xlen-1:0]       rd_data_a,
    output logic [xlen-1:0]       rd_data_b,
    output logic [reg_addr_w-1:0] reg_dest,
    output logic [uimm_w-1:0]     uimm,
    output logic [func_w-1:0]     opcode,
    output logic [instr_w-1:0]    out_instr,
    output logic [xlen-1:0]       curr_pc,
    output logic [reg_addr_w-1:0] reg_a,
    output logic [imm12_w-1:0]    reg_b
);

    instr_u word;
    logic   flush_q;
    logic   hold;
    logic   kill_dest;

    assign word = instr;

    // hazard now or stall already raised
    assign hold = hazard || alustall;

    // any of these turns the next slot into a no-write
    assign kill_dest = hold || decoder_flush || flush_q || icache_fetch_miss;

    always_ff @(posedge clk) begin
        if (reset) begin
            flush_q   <= 1'b0;
            reg_dest  <= '0;
            opcode    <= '0;
            rd_data_a <= '0;
            rd_data_b <= '0;
            uimm      <= '0;
        end else begin
            flush_q  <= decoder_flush;
            reg_dest <= kill_dest ? '0 : rd;
            // second cycle after a flush goes out as a fence
            opcode   <= flush_q ? func_bubble : func_code;
            // operands frozen while stalled
            if (!hold) begin
                rd_data_a <= rs1_data;
                rd_data_b <= rs2_data;
                uimm      <= uimm_next;
            end
        end
    end

    // raw fields and pc follow the instruction every cycle
    always_ff @(posedge clk) begin
        out_instr <= instr;
        curr_pc   <= prog_counter;
        reg_a     <= word.r.rs1;
        reg_b     <= word.i.imm;
    end

    // a flush never lets a destination through on the next output
    a_flush_kills_dest: assert property (@(posedge clk) disable iff (reset)
        decoder_flush |=> reg_dest == '0)
        else $error("reg_dest nonzero the cycle after a flush");

endmodule

// ==== decode/register_file.sv ====
// 32 x 64-bit integer register file, one write port, two async read ports
`timescale 1ns/100ps

module register_file
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    src_operand_if.consumer       src,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] destn_reg,
    input  logic [xlen-1:0]       destn_data,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    logic [xlen-1:0] regs [num_regs];
    logic            wr_valid;

    // x0 is hardwired, writes to it are dropped
    assign wr_valid = wr_en && (destn_reg != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[destn_reg] <= destn_data;
        end
    end

    // async read
    // same-cycle write shows up only after the edge, no bypass
    assign rs1_data = regs[src.rs1];
    assign rs2_data = regs[src.rs2];

    // x0 stays zero whatever the writeback stage sends
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0)
        else $error("register x0 holds a nonzero value");

endmodule

// ==== decode/hazard_detector.sv ====
// read-after-write check against alu, mem and wb destinations, with registered stall
`timescale 1ns/100ps

module hazard_detector
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    src_operand_if.consumer       src,
    input  logic [reg_addr_w-1:0] alu_reg_dest,
    input  logic [reg_addr_w-1:0] mem_reg_dest,
    input  logic [reg_addr_w-1:0] wb_reg_dest,
    input  logic                  alu_st_dec,
    output logic                  hazard,
    output logic                  alustall
);

    logic alu_hit;
    logic mem_hit;
    logic wb_hit;

    // one source against one in-flight destination, x0 never conflicts
    function automatic logic src_match(input logic [reg_addr_w-1:0] dest,
                                       input logic [reg_addr_w-1:0] rs,
                                       input logic                  used);
        return used && (rs == dest) && (dest != '0);
    endfunction

    // alu destination ignored while alu_st_dec is set
    assign alu_hit = !alu_st_dec &&
                     (src_match(alu_reg_dest, src.rs1, src.rs1_used) ||
                      src_match(alu_reg_dest, src.rs2, src.rs2_used));
    assign mem_hit = src_match(mem_reg_dest, src.rs1, src.rs1_used) ||
                     src_match(mem_reg_dest, src.rs2, src.rs2_used);
    assign wb_hit  = src_match(wb_reg_dest, src.rs1, src.rs1_used) ||
                     src_match(wb_reg_dest, src.rs2, src.rs2_used);

    assign hazard = alu_hit || mem_hit || wb_hit;

    // stall seen by fetch one cycle after the hazard
    always_ff @(posedge clk) begin
        if (reset) begin
            alustall <= 1'b0;
        end else begin
            alustall <= hazard;
        end
    end

    // nothing in flight means nothing to wait for
    a_no_dest_no_hazard: assert property (@(posedge clk) disable iff (reset)
        (alu_reg_dest == '0 && mem_reg_dest == '0 && wb_reg_dest == '0) |-> !hazard)
        else $error("hazard raised with no destination in flight");

endmodule

// ==== decode/instr_field_decoder.sv ====
// splits the instruction word into sources, destination, function code and upper immediate
`timescale 1ns/100ps

module instr_field_decoder
    import decode_pkg::*;
(
    input  logic [instr_w-1:0]    instr,
    src_operand_if.decoder        src,
    output logic [reg_addr_w-1:0] rd,
    output logic [func_w-1:0]     func_code,
    output logic [uimm_w-1:0]     uimm_next
);

    instr_u word;

    assign word = instr;

    // funct3 on top of the major opcode
    assign func_code = {word.r.funct3, word.r.opcode};

    always_comb begin
        // no sources unless the format names them
        src.rs1      = '0;
        src.rs2      = '0;
        src.rs1_used = 1'b0;
        src.rs2_used = 1'b0;
        rd           = word.r.rd;
        uimm_next    = '0;

        case (word.r.opcode)
            // register-register, both sources
            op_r, op_r_w: begin
                src.rs1      = word.r.rs1;
                src.rs2      = word.r.rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
            end
            // i format, rs2 slot is immediate and never a source
            op_load, op_imm, op_imm_w, op_jalr, op_system: begin
                src.rs1      = word.i.rs1;
                src.rs1_used = 1'b1;
            end
            op_store: begin
                src.rs1      = word.s.rs1;
                src.rs2      = word.s.rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
            end
            op_branch: begin
                src.rs1      = word.b.rs1;
                src.rs2      = word.b.rs2;
                src.rs1_used = 1'b1;
                src.rs2_used = 1'b1;
            end
            // lui and auipc take the upper 20 bits as they are
            op_lui, op_auipc: begin
                uimm_next = word.u.imm;
            end
            // jal immediate back in bit order 20..1
            op_jal: begin
                uimm_next = {word.j.imm_20, word.j.imm_19_12,
                             word.j.imm_11, word.j.imm_10_1};
            end
            // fence writes nothing
            op_fence: begin
                rd = '0;
            end
            default: begin
                // unknown opcode, no sources and no immediate
            end
        endcase
    end

endmodule

// ==== common/src_operand_if.sv ====
// source register numbers and use flags from the field decoder to its consumers
`timescale 1ns/100ps

interface src_operand_if
    import decode_pkg::*;
();

    // register numbers, zero when the format has no such source
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    // set per major opcode
    logic                  rs1_used;
    logic                  rs2_used;

    modport decoder (
        output rs1,
        output rs2,
        output rs1_used,
        output rs2_used
    );

    modport consumer (
        input rs1,
        input rs2,
        input rs1_used,
        input rs2_used
    );

endinterface

// ==== common/decode_pkg.sv ====
// decode stage shared widths, major opcodes and instruction format views
package decode_pkg;

    // datapath and field widths
    localparam int xlen       = 64;
    localparam int instr_w    = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int func_w     = 10;
    localparam int imm12_w    = 12;
    localparam int uimm_w     = 20;

    // major opcodes, rv64i base set
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_r_w    = 7'b0111011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm_w  = 7'b0011011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_fence  = 7'b0001111;
    localparam logic [6:0] op_system = 7'b1110011;

    // fence with funct3 zero, sent down the pipe after a flush
    localparam logic [func_w-1:0] func_bubble = {3'b000, op_fence};

    // one instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [imm12_w-1:0]    imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic                  imm_12;
            logic [5:0]            imm_10_5;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm_4_1;
            logic                  imm_11;
            logic [6:0]            opcode;
        } b;
        struct packed {
            logic [uimm_w-1:0]     imm;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
        struct packed {
            logic                  imm_20;
            logic [9:0]            imm_10_1;
            logic                  imm_11;
            logic [7:0]            imm_19_12;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } j;
    } instr_u;

endpackage
